/* Makefile */
TOP = tb_link_stim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

# the simulator exits cleanly either way, so the verdict comes from the printed result
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f
	verilator --lint-only --top-module link_stim_top -f files.f

clean:
	rm -rf obj_dir

/* common/stim_params.svh */
`ifndef STIM_PARAMS_SVH
`define STIM_PARAMS_SVH

// --------------------
// front-end geometry
// --------------------
`define NUM_VFATS          24   // front-end chips on the link
`define SBITS_PER_VFAT     8    // trigger bits per chip
`define SBIT_WIDTH         192  // NUM_VFATS * SBITS_PER_VFAT

// --------------------
// timing
// --------------------
`define FRAME_SLOTS        8    // bx slots in one pattern frame
`define SLOT_WIDTH         3    // slot counter bits
`define BC0_PERIOD         32   // cycles between bc0 strobes
`define BC0_CNT_WIDTH      5    // bx counter bits
`define STARTUP_CYCLES     600  // link settle time before any request
`define STARTUP_CNT_WIDTH  12
`define HOLDOFF_CYCLES     7    // idle cycles once busy drops
`define HOLDOFF_CNT_WIDTH  3

// --------------------
// payloads
// --------------------
`define REQ_WIDTH          32
`define REQ_INIT           32'haaaa_aaaa          // first request word
`define PAT_WIDTH          64                     // one byte per vfat, repeats every 8 vfats
`define PAT_EVEN           64'h00000000000000fe   // slot 0, exercises even encoder
`define PAT_ODD            64'h0000000000000001   // slot 1, exercises odd encoder

`endif

/* common/stim_pkg.sv */
`include "stim_params.svh"

package stim_pkg;

  // --------------------
  // s-bit frame
  // --------------------
  // same 192 wires seen two ways
  //   flat : whole word, used for the polarity xor
  //   vfat : one byte per chip, used for the pattern fill
  typedef union packed {
    logic [`SBIT_WIDTH-1:0]                     flat;
    logic [`NUM_VFATS-1:0][`SBITS_PER_VFAT-1:0] vfat;  // vfat[0] sits in bits 7:0
  } sbit_frame_t;

  // --------------------
  // request sequencer
  // --------------------
  typedef enum logic [1:0] {
    STARTUP = 2'd0,  // waiting for the link to settle
    ISSUE   = 2'd1,  // valid every cycle
    HOLDOFF = 2'd2   // link reported busy, backing off
  } req_state_t;

endpackage

/* files.f */
+incdir+common
common/stim_pkg.sv
logic/bx_timer.sv
logic/request_sequencer.sv
sbit/sbit_pattern_gen.sv
logic/link_stim_top.sv
tb/tb_link_stim.sv

/* logic/bx_timer.sv */
`timescale 1ns/1ps
`include "stim_params.svh"

module bx_timer (
  input  logic                   clk40,
  input  logic                   rst_n_i,
  output logic                   bc0_o,           // one cycle per orbit
  output logic [`SLOT_WIDTH-1:0] slot_o,          // position inside the pattern frame
  output logic                   startup_done_o   // sticky once the link has settled
);

  // last counter values before wrap / saturation
  localparam logic [`BC0_CNT_WIDTH-1:0]     BC_LAST      = `BC0_CNT_WIDTH'(`BC0_PERIOD - 1);
  localparam logic [`SLOT_WIDTH-1:0]        SLOT_LAST    = `SLOT_WIDTH'(`FRAME_SLOTS - 1);
  localparam logic [`STARTUP_CNT_WIDTH-1:0] STARTUP_LAST = `STARTUP_CNT_WIDTH'(`STARTUP_CYCLES);

  logic [`BC0_CNT_WIDTH-1:0]     bc_cnt;       // bunch crossing number in the short orbit
  logic                          bc_wrap;
  logic                          bc0_q;
  logic [`SLOT_WIDTH-1:0]        slot_cnt;
  logic [`STARTUP_CNT_WIDTH-1:0] startup_cnt;
  logic                          startup_done;

  // --------------------
  // bunch crossing zero
  // --------------------
  assign bc_wrap = (bc_cnt == BC_LAST);

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bc_cnt <= '0;
      bc0_q  <= 1'b0;
    end else begin
      bc_cnt <= bc_wrap ? '0 : bc_cnt + 1'b1;
      bc0_q  <= bc_wrap;   // registered, so first strobe lands on edge BC0_PERIOD
    end
  end

  // --------------------
  // frame slot
  // --------------------
  // free running, slot 0 carries the even pattern and slot 1 the odd one
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= (slot_cnt == SLOT_LAST) ? '0 : slot_cnt + 1'b1;
    end
  end

  // --------------------
  // startup wait
  // --------------------
  assign startup_done = (startup_cnt == STARTUP_LAST);  // saturates here

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      startup_cnt <= '0;
    end else if (!startup_done) begin
      startup_cnt <= startup_cnt + 1'b1;
    end
  end

  assign bc0_o          = bc0_q;
  assign slot_o         = slot_cnt;
  assign startup_done_o = startup_done;

  // strobe must stay a single-cycle pulse for the downstream ttc logic
  bc0_single_a : assert property (@(posedge clk40) disable iff (!rst_n_i)
    bc0_o |=> !bc0_o);

endmodule

/* logic/link_stim_top.sv */
`timescale 1ns/1ps
`include "stim_params.svh"

module link_stim_top import stim_pkg::*; (
  input  logic                  clk40,
  input  logic                  rst_n_i,
  input  logic                  busy_i,           // link tx back-pressure
  input  sbit_frame_t           invert_mask_i,    // per-pin polarity swap
  output logic                  bc0_o,
  output sbit_frame_t           sbits_o,
  output logic                  request_valid_o,
  output logic [`REQ_WIDTH-1:0] request_data_o
);

  logic [`SLOT_WIDTH-1:0] slot;           // timer -> pattern gen
  logic                   startup_done;   // timer -> sequencer

  // --------------------
  // timing
  // --------------------
  bx_timer u_bx_timer (
    .clk40          (clk40),
    .rst_n_i        (rst_n_i),
    .bc0_o          (bc0_o),
    .slot_o         (slot),
    .startup_done_o (startup_done)
  );

  // --------------------
  // register requests
  // --------------------
  request_sequencer u_request_sequencer (
    .clk40           (clk40),
    .rst_n_i         (rst_n_i),
    .startup_done_i  (startup_done),
    .busy_i          (busy_i),
    .request_valid_o (request_valid_o),
    .request_data_o  (request_data_o)
  );

  // --------------------
  // s-bit frames
  // --------------------
  sbit_pattern_gen u_sbit_pattern_gen (
    .clk40         (clk40),
    .rst_n_i       (rst_n_i),
    .slot_i        (slot),
    .invert_mask_i (invert_mask_i),
    .sbits_o       (sbits_o)
  );

endmodule

/* logic/request_sequencer.sv */
`timescale 1ns/1ps
`include "stim_params.svh"

module request_sequencer import stim_pkg::*; (
  input  logic                  clk40,
  input  logic                  rst_n_i,
  input  logic                  startup_done_i,   // level from bx_timer
  input  logic                  busy_i,           // level from the link tx
  output logic                  request_valid_o,  // level, high for the whole issue phase
  output logic [`REQ_WIDTH-1:0] request_data_o
);

  localparam logic [`HOLDOFF_CNT_WIDTH-1:0] HOLD_LOAD =
    `HOLDOFF_CNT_WIDTH'(`HOLDOFF_CYCLES);

  req_state_t                    state_q;
  req_state_t                    state_d;
  logic [`HOLDOFF_CNT_WIDTH-1:0] hold_cnt_q;   // idle cycles still to wait
  logic [`HOLDOFF_CNT_WIDTH-1:0] hold_cnt_d;
  logic [`REQ_WIDTH-1:0]         data_q;
  logic                          valid;
  logic                          accept;       // word goes out this edge

  assign valid  = (state_q == ISSUE);
  assign accept = valid & ~busy_i;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_d    = state_q;
    hold_cnt_d = hold_cnt_q;
    case (state_q)
      STARTUP: begin
        if (startup_done_i) begin
          state_d = ISSUE;            // valid one cycle after done is seen
        end
      end
      ISSUE: begin
        if (busy_i) begin
          state_d    = HOLDOFF;       // drop valid on the next cycle
          hold_cnt_d = HOLD_LOAD;
        end
      end
      HOLDOFF: begin
        if (busy_i) begin
          hold_cnt_d = HOLD_LOAD;     // restart the wait while still busy
        end else if (hold_cnt_q == '0) begin
          state_d = ISSUE;
        end else begin
          hold_cnt_d = hold_cnt_q - 1'b1;
        end
      end
      default: begin
        state_d = STARTUP;            // unused encoding, go back and wait
      end
    endcase
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= STARTUP;
      hold_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      hold_cnt_q <= hold_cnt_d;
    end
  end

  // request payload, toggles so the far end sees every bit move
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_q <= `REQ_INIT;
    end else if (accept) begin
      data_q <= ~data_q;              // held through busy and holdoff
    end
  end

  assign request_valid_o = valid;
  assign request_data_o  = data_q;

  // nothing may reach the link before bx_timer reports it settled
  valid_after_startup_a : assert property (@(posedge clk40) disable iff (!rst_n_i)
    request_valid_o |-> startup_done_i);

  // back-pressure takes effect within one cycle
  busy_backoff_a : assert property (@(posedge clk40) disable iff (!rst_n_i)
    busy_i |=> !request_valid_o);

endmodule

/* sbit/sbit_pattern_gen.sv */
`timescale 1ns/1ps
`include "stim_params.svh"

module sbit_pattern_gen import stim_pkg::*; (
  input  logic                   clk40,
  input  logic                   rst_n_i,
  input  logic [`SLOT_WIDTH-1:0] slot_i,          // frame slot from bx_timer
  input  sbit_frame_t            invert_mask_i,   // 1 = pin is polarity swapped on the board
  output sbit_frame_t            sbits_o          // one frame per bx, one cycle behind slot_i
);

  localparam int PAT_BYTES = `PAT_WIDTH / `SBITS_PER_VFAT;  // pattern repeats every 8 vfats

  logic [`PAT_WIDTH-1:0] pat;       // pattern picked for this slot
  sbit_frame_t           fill;      // pattern spread over all vfats
  sbit_frame_t           frame_d;   // after polarity swap
  sbit_frame_t           frame_q;

  // --------------------
  // pattern select
  // --------------------
  // even pattern then odd pattern, quiet for the rest of the frame
  // so latency through the cluster finder is easy to read
  always_comb begin
    if (slot_i == '0) begin
      pat = `PAT_EVEN;
    end else if (slot_i == `SLOT_WIDTH'(1)) begin
      pat = `PAT_ODD;
    end else begin
      pat = '0;
    end
  end

  // --------------------
  // vfat fill
  // --------------------
  always_comb begin
    fill.flat = '0;
    for (int v = 0; v < `NUM_VFATS; v++) begin
      // vfat v gets byte v mod 8
      fill.vfat[v] = pat[(v % PAT_BYTES) * `SBITS_PER_VFAT +: `SBITS_PER_VFAT];
    end
  end

  // --------------------
  // polarity + output
  // --------------------
  assign frame_d.flat = fill.flat ^ invert_mask_i.flat;  // one xor per pin

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_q <= '0;
    end else begin
      frame_q <= frame_d;
    end
  end

  assign sbits_o = frame_q;

  // quiet slots must show the bare inversion mask on the next frame
  quiet_slot_mask_a : assert property (@(posedge clk40) disable iff (!rst_n_i)
    (slot_i >= `SLOT_WIDTH'(2)) |=> (sbits_o.flat == $past(invert_mask_i.flat)));

endmodule

/* tb/tb_link_stim.sv */
`timescale 1ns/1ps
`include "stim_params.svh"

module tb_link_stim import stim_pkg::*;;

  logic                  clk40;
  logic                  rst_n_i;
  logic                  busy_i;
  sbit_frame_t           invert_mask_i;
  logic                  bc0_o;
  sbit_frame_t           sbits_o;
  logic                  request_valid_o;
  logic [`REQ_WIDTH-1:0] request_data_o;

  int                    err_cnt;       // failed checks over the whole run
  int                    tests_run;
  int                    tests_failed;
  int                    cycle_cnt;     // rising edges since reset release
  int                    frame_phase;   // slot of the frame now on sbits_o
  logic                  exp_valid;     // reference model of the request stream
  logic [`REQ_WIDTH-1:0] exp_data;
  logic [`REQ_WIDTH-1:0] last_sent;     // last word that went out with busy low
  logic [31:0]           lfsr_state;

  link_stim_top dut (
    .clk40           (clk40),
    .rst_n_i         (rst_n_i),
    .busy_i          (busy_i),
    .invert_mask_i   (invert_mask_i),
    .bc0_o           (bc0_o),
    .sbits_o         (sbits_o),
    .request_valid_o (request_valid_o),
    .request_data_o  (request_data_o)
  );

  always #4 clk40 = ~clk40;   // 8 ns period

  // --------------------
  // helpers
  // --------------------
  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic random_bits(input int n, output logic [`SBIT_WIDTH-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);   // one step per bit taken
      val[i] = lfsr_state[0];
    end
  endtask

  // unmasked frame for a slot
  // vfat v carries byte v mod 8 so bit i maps to bit i mod 64
  function automatic sbit_frame_t expected_frame(input int phase);
    sbit_frame_t            f;
    logic [`PAT_WIDTH-1:0]  pat;
    if (phase == 0) begin
      pat = `PAT_EVEN;
    end else if (phase == 1) begin
      pat = `PAT_ODD;
    end else begin
      pat = '0;   // quiet slots
    end
    for (int i = 0; i < `SBIT_WIDTH; i++) begin
      f.flat[i] = pat[i % `PAT_WIDTH];
    end
    return f;
  endfunction

  // model the word that leaves on the next edge and land 1 ns after that edge
  task automatic tick();
    if (exp_valid && !busy_i) begin
      last_sent = exp_data;
      exp_data  = ~exp_data;
    end
    @(posedge clk40);
    #1;
    cycle_cnt++;
    frame_phase = (frame_phase + 1) % `FRAME_SLOTS;
  endtask

  task automatic compare_requests();
    if (request_valid_o !== exp_valid) begin
      $display("error %0t: request_valid_o is %b, expected %b (edge %0d)",
               $time, request_valid_o, exp_valid, cycle_cnt);
      err_cnt++;
    end
    if (request_data_o !== exp_data) begin
      $display("error %0t: request_data_o is %h, expected %h", $time, request_data_o, exp_data);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (err_cnt == start_err) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failing checks", name, err_cnt - start_err);
      tests_failed++;
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic reset_values();
    int start_err;
    start_err = err_cnt;
    rst_n_i = 1'b0;
    repeat (2) begin
      @(posedge clk40);
      #1;
      if (request_valid_o !== 1'b0 || bc0_o !== 1'b0 || sbits_o.flat !== '0) begin
        $display("error %0t: outputs not quiet during reset", $time);
        err_cnt++;
      end
      compare_requests();   // data must sit at REQ_INIT
    end
    rst_n_i = 1'b1;
    cycle_cnt = 0;
    tick();
    if (bc0_o !== 1'b0) begin
      $display("error %0t: bc0_o high right after reset", $time);
      err_cnt++;
    end
    compare_requests();
    report_test("reset values", start_err);
  endtask

  task automatic bc0_spacing();
    int start_err;
    int waited;
    start_err = err_cnt;
    waited = 0;
    while (bc0_o !== 1'b1 && waited < 2 * `BC0_PERIOD) begin
      tick();
      waited++;
    end
    if (bc0_o !== 1'b1) begin
      $display("no bc0 pulse appeared within %0d cycles", 2 * `BC0_PERIOD);
      err_cnt++;
    end else begin
      if (cycle_cnt != `BC0_PERIOD) begin
        $display("error %0t: first bc0 on edge %0d, expected %0d", $time, cycle_cnt, `BC0_PERIOD);
        err_cnt++;
      end
      for (int p = 0; p < 3; p++) begin   // three gaps between four pulses
        for (int k = 1; k <= `BC0_PERIOD; k++) begin
          tick();
          if (bc0_o !== (k == `BC0_PERIOD)) begin
            $display("error %0t: bc0_o is %b, %0d cycles after last pulse", $time, bc0_o, k);
            err_cnt++;
          end
        end
      end
    end
    report_test("bc0 spacing", start_err);
  endtask

  task automatic zero_mask_frames();
    int          start_err;
    int          waited;
    sbit_frame_t exp;
    start_err = err_cnt;
    waited = 0;
    // land on a quiet frame so the next busy one is the even pattern
    while (sbits_o.flat !== '0 && waited < 2 * `FRAME_SLOTS) begin
      tick();
      waited++;
    end
    while (sbits_o.flat === '0 && waited < 4 * `FRAME_SLOTS) begin
      tick();
      waited++;
    end
    if (sbits_o.flat === '0) begin
      $display("no non-zero s-bit frame found with a zero mask");
      err_cnt++;
    end else begin
      frame_phase = 0;   // sync model to the even frame
      for (int k = 0; k < `FRAME_SLOTS; k++) begin
        if (k > 0) begin
          tick();
        end
        exp = expected_frame(frame_phase);
        if (sbits_o.flat !== exp.flat) begin
          $display("error %0t: slot %0d frame %h, expected %h",
                   $time, frame_phase, sbits_o.flat, exp.flat);
          err_cnt++;
        end
      end
    end
    report_test("zero mask frames", start_err);
  endtask

  task automatic polarity_inversion();
    int                     start_err;
    logic [`SBIT_WIDTH-1:0] mask;
    sbit_frame_t            exp;
    start_err = err_cnt;
    random_bits(`SBIT_WIDTH, mask);
    invert_mask_i.flat = mask;   // held for the rest of the run
    for (int k = 0; k < 2 * `FRAME_SLOTS; k++) begin
      tick();
      exp = expected_frame(frame_phase);
      exp.flat = exp.flat ^ mask;   // quiet slots show the bare mask
      if (sbits_o.flat !== exp.flat) begin
        $display("error %0t: slot %0d frame %h, expected %h",
                 $time, frame_phase, sbits_o.flat, exp.flat);
        err_cnt++;
      end
    end
    report_test("polarity inversion", start_err);
  endtask

  task automatic startup_and_alternation();
    int start_err;
    start_err = err_cnt;
    compare_requests();   // still inside the startup wait
    while (cycle_cnt < `STARTUP_CYCLES + 24) begin
      tick();
      exp_valid = (cycle_cnt >= `STARTUP_CYCLES + 1);   // one edge after startup done
      compare_requests();
    end
    report_test("startup and alternation", start_err);
  endtask

  task automatic busy_holdoff();
    int                     start_err;
    int                     len;
    logic [`SBIT_WIDTH-1:0] r;
    start_err = err_cnt;
    for (int round = 0; round < 3; round++) begin
      random_bits(3, r);
      len = int'(r[2:0]) + 1;   // 1 to 8 busy cycles
      busy_i = 1'b1;
      for (int k = 0; k < len; k++) begin
        tick();
        exp_valid = 1'b0;   // drops on the first busy edge
        compare_requests();
      end
      busy_i = 1'b0;
      for (int k = 1; k <= `HOLDOFF_CYCLES + 1; k++) begin
        tick();
        exp_valid = (k == `HOLDOFF_CYCLES + 1);
        compare_requests();
      end
      if (request_data_o !== ~last_sent) begin
        $display("error %0t: word after holdoff %h is not the inverse of %h",
                 $time, request_data_o, last_sent);
        err_cnt++;
      end
      repeat (4) begin   // alternation resumes
        tick();
        compare_requests();
      end
    end
    report_test("busy holdoff", start_err);
  endtask

  // --------------------
  // main
  // --------------------
  initial begin
    clk40         = 1'b0;
    rst_n_i       = 1'b0;
    busy_i        = 1'b0;
    invert_mask_i = '0;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycle_cnt     = 0;
    frame_phase   = 0;
    exp_valid     = 1'b0;
    exp_data      = `REQ_INIT;
    last_sent     = `REQ_INIT;
    lfsr_state    = 32'hdc8c;
    reset_values();
    bc0_spacing();
    zero_mask_frames();
    polarity_inversion();
    startup_and_alternation();
    busy_holdoff();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog at twice the startup wait plus margin
  initial begin
    #((`STARTUP_CYCLES + 400) * 8 * 2);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule
